// File: source/card_status_pkg.sv
package card_status_pkg;

    // Sound transfer counter
    localparam int SOUND_COUNT_W = 16;

    typedef logic [SOUND_COUNT_W-1:0] sound_count_t;

    // Counter bit that the status LED follows while sound is active
    localparam int unsigned ACTIVITY_BLINK_BIT = 8;

    // Raw Apple II bus clock levels from outside the clk_logic_w domain
    typedef struct packed {
        logic phi1;
        logic q3;
    } bus_clocks_t;

    // Board indicator outputs
    typedef struct packed {
        logic status_led;   // Heartbeat or sound blink
        logic clk_2m_led;   // Divided q3
        logic phi1_led;     // Divided phi1
    } status_leds_t;

    // Which rule last set the status LED
    typedef enum logic {
        LED_HEARTBEAT = 1'b0,
        LED_SOUND     = 1'b1
    } led_mode_e;

endpackage

// File: source/bus_clock_monitor.sv
`timescale 1ns/1ns

module bus_clock_monitor #(
    parameter int CLOCK_DIV_BITS = 11
) (
    input  logic                       clk_logic_w,
    input  logic                       system_reset_n_w,
    input  card_status_pkg::bus_clocks_t bus_clocks_i,
    output logic                       phi1_led_o,
    output logic                       clk_2m_led_o
);

    import card_status_pkg::*;

    // Slot of each clock in the packed struct
    localparam int PHI1_IDX = 1;
    localparam int Q3_IDX   = 0;
    localparam int NUM_CLKS = 2;

    bus_clocks_t sync1_r;   // First synchronizer stage
    bus_clocks_t sync2_r;   // Second synchronizer stage
    bus_clocks_t prev_r;    // Level one cycle back, for edge detect
    bus_clocks_t rise_r;    // Registered rising edge pulses

    logic [NUM_CLKS-1:0]       rise_vec_w;
    logic [CLOCK_DIV_BITS-1:0] div_cnt_r [NUM_CLKS];

    // Two-flop synchronizer and edge history
    always_ff @(posedge clk_logic_w) begin
        sync1_r <= bus_clocks_i;
        sync2_r <= sync1_r;
        prev_r  <= sync2_r;
    end

    // One-cycle pulse per rising edge of each clock
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            rise_r <= '0;
        end else begin
            rise_r <= sync2_r & ~prev_r;
        end
    end

    assign rise_vec_w = rise_r;

    // Edge counters, one per bus clock
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            for (int i = 0; i < NUM_CLKS; i++) begin
                div_cnt_r[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CLKS; i++) begin
                if (rise_vec_w[i]) begin
                    div_cnt_r[i] <= div_cnt_r[i] + 1'b1;
                end
            end
        end
    end

    /*
     * The top bit of each counter toggles once every
     * 2**(CLOCK_DIV_BITS-1) edges and so blinks slowly enough to see on a board LED
     */
    assign phi1_led_o   = div_cnt_r[PHI1_IDX][CLOCK_DIV_BITS-1];
    assign clk_2m_led_o = div_cnt_r[Q3_IDX][CLOCK_DIV_BITS-1];    // q3 runs at 2 MHz

endmodule

// File: source/sound_activity_monitor.sv
`timescale 1ns/1ns

module sound_activity_monitor (
    input  logic                          clk_logic_w,
    input  logic                          system_reset_n_w,
    input  card_status_pkg::sound_count_t sound_count_i,
    input  logic                          period_tick_i,
    output logic                          activity_o,
    output logic                          blink_bit_o
);

    import card_status_pkg::*;

    sound_count_t prev_count_r;   // Counter value one cycle back
    logic         change_w;
    logic         activity_r;

    // Previous value follows the counter every cycle
    always_ff @(posedge clk_logic_w) begin
        prev_count_r <= sound_count_i;
    end

    assign change_w = (sound_count_i != prev_count_r);

    // Activity flag
    // A change in the tick cycle keeps the flag for the next period
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            activity_r <= 1'b0;
        end else if (change_w) begin
            activity_r <= 1'b1;
        end else if (period_tick_i) begin
            activity_r <= 1'b0;     // Cleared at period end
        end
    end

    assign activity_o  = activity_r;
    assign blink_bit_o = sound_count_i[ACTIVITY_BLINK_BIT];   // Live counter bit

endmodule

// File: source/status_led_driver.sv
`timescale 1ns/1ns

module status_led_driver #(
    parameter int HEARTBEAT_CYCLES = 10_000_000
) (
    input  logic                       clk_logic_w,
    input  logic                       system_reset_n_w,
    input  logic                       activity_i,
    input  logic                       blink_bit_i,
    output logic                       period_tick_o,
    output logic                       heartbeat_pulse_o,
    output logic                       status_led_o,
    output card_status_pkg::led_mode_e sound_mode_o
);

    import card_status_pkg::*;

    localparam int COUNT_W = $clog2(HEARTBEAT_CYCLES);
    localparam logic [COUNT_W-1:0] LAST_COUNT = COUNT_W'(HEARTBEAT_CYCLES - 1);

    logic [COUNT_W-1:0] period_cnt_r;
    logic               period_end_w;
    logic               status_led_r;
    led_mode_e          mode_r;

    // Heartbeat period counter that wraps at LAST_COUNT
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            period_cnt_r <= '0;
        end else if (period_end_w) begin
            period_cnt_r <= '0;
        end else begin
            period_cnt_r <= period_cnt_r + 1'b1;
        end
    end

    assign period_end_w = (period_cnt_r == LAST_COUNT);

    // Same cycle drives the activity clear and the external pulse
    assign period_tick_o     = period_end_w;
    assign heartbeat_pulse_o = period_end_w;

    /*
     * LED decision at the end of each period.
     * Sound activity makes the LED follow the counter bit, so a busy
     * sound engine gives an irregular blink; a quiet one gives a
     * steady heartbeat toggle.
     */
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            status_led_r <= 1'b0;
            mode_r       <= LED_HEARTBEAT;
        end else if (period_end_w) begin
            if (activity_i) begin
                status_led_r <= blink_bit_i;
                mode_r       <= LED_SOUND;
            end else begin
                status_led_r <= ~status_led_r;  // Plain heartbeat
                mode_r       <= LED_HEARTBEAT;
            end
        end
    end

    assign status_led_o = status_led_r;
    assign sound_mode_o = mode_r;

endmodule

// File: source/card_status_top.sv
`timescale 1ns/1ns

module card_status_top #(
    parameter int HEARTBEAT_CYCLES = 10_000_000,   // Period of the status heartbeat
    parameter int CLOCK_DIV_BITS   = 11            // Bus clock divider width
) (
    input  logic                          clk_logic_w,
    input  logic                          system_reset_n_w,
    input  card_status_pkg::bus_clocks_t  bus_clocks_i,
    input  card_status_pkg::sound_count_t sound_count_i,
    output card_status_pkg::status_leds_t leds_o,
    output logic                          heartbeat_pulse_o,
    output card_status_pkg::led_mode_e    sound_mode_o
);

    logic phi1_led_w;
    logic clk_2m_led_w;
    logic status_led_w;
    logic activity_w;
    logic blink_bit_w;
    logic period_tick_w;

    // Bus clock indicators
    bus_clock_monitor #(
        .CLOCK_DIV_BITS(CLOCK_DIV_BITS)
    ) i_bus_clock_monitor (
        .clk_logic_w     (clk_logic_w),
        .system_reset_n_w(system_reset_n_w),
        .bus_clocks_i    (bus_clocks_i),
        .phi1_led_o      (phi1_led_w),
        .clk_2m_led_o    (clk_2m_led_w)
    );

    // Sound counter change detect
    sound_activity_monitor i_sound_activity_monitor (
        .clk_logic_w     (clk_logic_w),
        .system_reset_n_w(system_reset_n_w),
        .sound_count_i   (sound_count_i),
        .period_tick_i   (period_tick_w),
        .activity_o      (activity_w),
        .blink_bit_o     (blink_bit_w)
    );

    status_led_driver #(
        .HEARTBEAT_CYCLES(HEARTBEAT_CYCLES)
    ) i_status_led_driver (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .activity_i       (activity_w),
        .blink_bit_i      (blink_bit_w),
        .period_tick_o    (period_tick_w),
        .heartbeat_pulse_o(heartbeat_pulse_o),
        .status_led_o     (status_led_w),
        .sound_mode_o     (sound_mode_o)
    );

    // Indicator bundle
    assign leds_o = '{
        status_led: status_led_w,
        clk_2m_led: clk_2m_led_w,
        phi1_led:   phi1_led_w
    };

endmodule

// File: verification/card_status_sva.sv
`timescale 1ns/1ns

module card_status_sva #(
    parameter int OUT_W = 1
) (
    input logic             clk_logic_w,
    input logic             system_reset_n_w,
    input logic             pulse_i,        // Single-cycle pulse to watch
    input logic [OUT_W-1:0] reset_outs_i,   // Outputs that must clear in reset
    input logic             tick_i,
    input logic             change_i,
    input logic             activity_i
);

    // Heartbeat and period tick never stretch
    a_pulse_width: assert property (
        @(posedge clk_logic_w) disable iff (!system_reset_n_w)
        pulse_i |=> !pulse_i
    ) else $error("pulse held longer than one cycle");

    a_reset_values: assert property (
        @(posedge clk_logic_w)
        !system_reset_n_w |=> (reset_outs_i == '0)
    ) else $error("output not cleared by reset");

    // Tick without a counter change ends the activity flag
    a_activity_clear: assert property (
        @(posedge clk_logic_w) disable iff (!system_reset_n_w)
        (tick_i && !change_i) |=> !activity_i
    ) else $error("activity flag not cleared after period tick");

endmodule

bind status_led_driver card_status_sva #(
    .OUT_W(3)
) i_driver_sva (
    .clk_logic_w     (clk_logic_w),
    .system_reset_n_w(system_reset_n_w),
    .pulse_i         (heartbeat_pulse_o),
    .reset_outs_i    ({status_led_o, sound_mode_o, heartbeat_pulse_o}),
    .tick_i          (1'b0),
    .change_i        (1'b0),
    .activity_i      (1'b0)
);

bind sound_activity_monitor card_status_sva #(
    .OUT_W(1)
) i_monitor_sva (
    .clk_logic_w     (clk_logic_w),
    .system_reset_n_w(system_reset_n_w),
    .pulse_i         (period_tick_i),
    .reset_outs_i    (activity_o),
    .tick_i          (period_tick_i),
    .change_i        (change_w),
    .activity_i      (activity_o)
);

// File: verification/card_status_tb.sv
`timescale 1ns/1ns

module card_status_tb;

    import card_status_pkg::*;

    localparam int HB_CYCLES    = 20;
    localparam int DIV_BITS     = 3;
    localparam int SOUND_ROUNDS = 3;
    localparam int BUS_ROUNDS   = 2;
    localparam int MAX_EDGES    = 12;     // Upper bound of random edge counts
    localparam int TIMEOUT_CYCLES = 4 + 8 * HB_CYCLES + 2 * SOUND_ROUNDS * HB_CYCLES
        + HB_CYCLES + BUS_ROUNDS * (16 * MAX_EDGES + 4) + 1200;

    logic         clk_logic_w;
    logic         system_reset_n_w;
    bus_clocks_t  bus_clocks;
    sound_count_t sound_count;
    status_leds_t leds;
    logic         heartbeat_pulse;
    led_mode_e    sound_mode;

    int          errors;
    int          checks;
    int          tests_done;
    int          cycle_cnt = 0;
    int          since_pulse;     // Falling edges since the last heartbeat
    int          phi1_edges;
    int          q3_edges;
    logic [31:0] rng_state;
    logic        exp_status_led;
    logic        exp_phi1_led;
    logic        exp_clk_2m_led;
    led_mode_e   exp_mode;

    card_status_top #(
        .HEARTBEAT_CYCLES(HB_CYCLES),
        .CLOCK_DIV_BITS  (DIV_BITS)
    ) i_card_status_top (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .bus_clocks_i     (bus_clocks),
        .sound_count_i    (sound_count),
        .leds_o           (leds),
        .heartbeat_pulse_o(heartbeat_pulse),
        .sound_mode_o     (sound_mode)
    );

    initial begin
        clk_logic_w = 1'b0;
        forever #20 clk_logic_w = ~clk_logic_w;
    end

    // Run limit
    always @(posedge clk_logic_w) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic sound_count_t random_count();
        rng_state = xorshift32(rng_state);
        return rng_state[SOUND_COUNT_W-1:0];
    endfunction

    function automatic int random_range(input int n);
        rng_state = xorshift32(rng_state);
        return 1 + int'(rng_state % 32'(n));   // 1 to n
    endfunction

    // Divider LED is the top counter bit after wrap
    function automatic logic led_bit(input int edges);
        int wrapped;
        wrapped = edges % (1 << DIV_BITS);
        return wrapped[DIV_BITS-1];
    endfunction

    function automatic status_leds_t expected_leds();
        status_leds_t e;
        e.status_led = exp_status_led;
        e.clk_2m_led = exp_clk_2m_led;
        e.phi1_led   = exp_phi1_led;
        return e;
    endfunction

    task automatic check_leds(input status_leds_t got, input status_leds_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s, leds %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_mode(input led_mode_e got, input led_mode_e exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s, mode %s (%b), expected %s",
                     $time, what, got.name(), got, exp.name());
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Error at %0t ns: %s, %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_done++;
        $display("Test %s finished with %0d errors", name, errors - errors_before);
    endtask

    // Stops on the falling edge where the pulse is high
    task automatic wait_pulse(output int waited);
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < 2 * HB_CYCLES) begin
            @(negedge clk_logic_w);
            waited++;
            seen = (heartbeat_pulse === 1'b1);
        end
        if (!seen) begin
            errors++;
            $display("The heartbeat pulse did not arrive within %0d cycles", 2 * HB_CYCLES);
        end
    endtask

    // One cycle past a pulse the LED rule has been applied
    task automatic finish_period(input logic active, input logic blink);
        @(negedge clk_logic_w);
        if (active) begin
            exp_status_led = blink;
            exp_mode       = LED_SOUND;
        end else begin
            exp_status_led = ~exp_status_led;
            exp_mode       = LED_HEARTBEAT;
        end
        check_bit(heartbeat_pulse, 1'b0, "pulse width");
        check_leds(leds, expected_leds(), "after period end");
        check_mode(sound_mode, exp_mode, "after period end");
        since_pulse = 1;
    endtask

    // Quiet sound counter keeps the heartbeat toggling
    task automatic idle_cycle();
        @(negedge clk_logic_w);
        since_pulse++;
        if (since_pulse == 1) begin
            exp_status_led = ~exp_status_led;
        end
        if (since_pulse == HB_CYCLES) begin
            check_bit(heartbeat_pulse, 1'b1, "heartbeat during bus test");
            since_pulse = 0;
        end
    endtask

    task automatic drive_edges(input logic on_phi1, input int count);
        repeat (count) begin
            if (on_phi1) bus_clocks.phi1 = 1'b1;
            else bus_clocks.q3 = 1'b1;
            repeat (4) idle_cycle();
            if (on_phi1) bus_clocks.phi1 = 1'b0;
            else bus_clocks.q3 = 1'b0;
            repeat (4) idle_cycle();
        end
    endtask

    task automatic reset_values();
        int errors_before;
        errors_before    = errors;
        system_reset_n_w = 1'b0;
        exp_status_led   = 1'b0;
        exp_phi1_led     = 1'b0;
        exp_clk_2m_led   = 1'b0;
        exp_mode         = LED_HEARTBEAT;
        repeat (4) begin
            @(negedge clk_logic_w);
            check_leds(leds, expected_leds(), "during reset");
            check_bit(heartbeat_pulse, 1'b0, "pulse during reset");
            check_mode(sound_mode, exp_mode, "during reset");
        end
        system_reset_n_w = 1'b1;     // Release on the falling edge
        @(negedge clk_logic_w);
        check_leds(leds, expected_leds(), "after reset release");
        check_bit(heartbeat_pulse, 1'b0, "pulse after reset release");
        check_mode(sound_mode, exp_mode, "after reset release");
        report_test("reset_values", errors_before);
    endtask

    task automatic heartbeat_period();
        int errors_before;
        int waited;
        errors_before = errors;
        // Count starts at 0 on release and pulses at HB_CYCLES-1
        // The first cycle after release was already spent in reset_values
        wait_pulse(waited);
        check_count(waited + 1, HB_CYCLES - 1, "first pulse after reset");
        finish_period(1'b0, 1'b0);
        repeat (3) begin
            wait_pulse(waited);
            check_count(waited, HB_CYCLES - 1, "pulse interval");   // From the cycle after a pulse
            finish_period(1'b0, 1'b0);
        end
        report_test("heartbeat_period", errors_before);
    endtask

    task automatic idle_heartbeat();
        int errors_before;
        int waited;
        errors_before = errors;
        repeat (4) begin
            wait_pulse(waited);
            finish_period(1'b0, 1'b0);
        end
        report_test("idle_heartbeat", errors_before);
    endtask

    task automatic sound_activity_blink();
        int           errors_before;
        int           waited;
        sound_count_t value;
        logic         changed;
        errors_before = errors;
        repeat (SOUND_ROUNDS) begin
            changed = 1'b0;
            repeat (5) begin
                value = random_count();
                if (value != sound_count) changed = 1'b1;
                sound_count = value;
                @(negedge clk_logic_w);
            end
            wait_pulse(waited);
            finish_period(changed, sound_count[ACTIVITY_BLINK_BIT]);
            // No change in this period
            wait_pulse(waited);
            finish_period(1'b0, 1'b0);
        end
        report_test("sound_activity_blink", errors_before);
    endtask

    task automatic bus_clock_indicators();
        int errors_before;
        int waited;
        int k;
        int m;
        errors_before = errors;
        phi1_edges    = 0;
        q3_edges      = 0;
        wait_pulse(waited);
        finish_period(1'b0, 1'b0);
        repeat (BUS_ROUNDS) begin
            k = random_range(MAX_EDGES);
            m = random_range(MAX_EDGES);
            drive_edges(1'b1, k);
            drive_edges(1'b0, m);
            phi1_edges += k;
            q3_edges   += m;
            repeat (4) idle_cycle();
            exp_phi1_led   = led_bit(phi1_edges);
            exp_clk_2m_led = led_bit(q3_edges);
            check_leds(leds, expected_leds(), "bus clock indicators");
        end
        report_test("bus_clock_indicators", errors_before);
    endtask

    initial begin
        system_reset_n_w = 1'b0;
        bus_clocks       = '0;
        sound_count      = '0;
        errors           = 0;
        checks           = 0;
        tests_done       = 0;
        since_pulse      = 0;
        rng_state        = 32'h519b_a85a;

        reset_values();
        heartbeat_period();
        idle_heartbeat();
        sound_activity_blink();
        bus_clock_indicators();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: card_status_top.f
source/card_status_pkg.sv
source/bus_clock_monitor.sv
source/sound_activity_monitor.sv
source/status_led_driver.sv
source/card_status_top.sv
verification/card_status_sva.sv
verification/card_status_tb.sv

// File: Bender.yml
package:
  name: card_status

sources:
  - files:
      - source/card_status_pkg.sv
      - source/bus_clock_monitor.sv
      - source/sound_activity_monitor.sv
      - source/status_led_driver.sv
      - source/card_status_top.sv
  - target: test
    files:
      - verification/card_status_sva.sv
      - verification/card_status_tb.sv
